// ==== hdl/lbPkg.sv ====
package lbPkg;

    localparam int SQN_WIDTH = 7;

    typedef logic [SQN_WIDTH-1:0] sqnT;
    typedef logic [SQN_WIDTH-1:0] loadSqnT;
    typedef logic [31:0]          addrT;
    typedef logic [29:0]          wordAddrT;
    typedef logic [1:0]           accSizeT;
    typedef logic [31:0]          pcT;

    localparam accSizeT ACC_BYTE = 2'd0;
    localparam accSizeT ACC_HALF = 2'd1;

    // True when a equals b or comes before it in wraparound order
    function automatic logic isNotOlder(input logic [SQN_WIDTH-1:0] a,
                                        input logic [SQN_WIDTH-1:0] b);
        logic signed [SQN_WIDTH-1:0] diff;
        diff = $signed(a - b);
        return diff <= 0;
    endfunction

    // Byte overlap of a store with a load where both are given as address and size code
    function automatic logic bytesOverlap(input addrT    storeAddr,
                                          input accSizeT storeSize,
                                          input addrT    loadAddr,
                                          input accSizeT loadSize);
        wordAddrT storeWord;
        wordAddrT loadWord;
        logic     laneMatch;
        storeWord = storeAddr[31:2];
        loadWord  = loadAddr[31:2];
        case (storeSize)
            ACC_BYTE: laneMatch = (loadSize > ACC_BYTE) || (loadAddr[1:0] == storeAddr[1:0]);
            ACC_HALF: laneMatch = (loadSize > ACC_HALF) || (loadAddr[1] == storeAddr[1]);
            // A word store covers every byte of the word
            default:  laneMatch = 1'b1;
        endcase
        return (storeWord == loadWord) && laneMatch;
    endfunction

endpackage

// ==== hdl/lbEntryIf.sv ====
`timescale 1ns/10ps

// Registered contents of the load table as seen by both store checkers
interface lbEntryIf
    import lbPkg::*;
#(
    parameter int NUM_ENTRIES = 8
) ();

    logic [NUM_ENTRIES-1:0] valid;
    loadSqnT                loadSqN [NUM_ENTRIES];
    addrT                   addr    [NUM_ENTRIES];
    accSizeT                size    [NUM_ENTRIES];

    modport tableSide (
        output valid,
        output loadSqN,
        output addr,
        output size
    );

    modport checkerSide (
        input valid,
        input loadSqN,
        input addr,
        input size
    );

endinterface

// ==== hdl/conflictIf.sv ====
`timescale 1ns/10ps

// One store port's conflict result
// The fields count only while hit is set
interface conflictIf
    import lbPkg::*;
();

    logic    hit;
    sqnT     sqN;
    loadSqnT loadSqN;
    pcT      pc;

    modport reporter (
        output hit,
        output sqN,
        output loadSqN,
        output pc
    );

    modport arbiter (
        input hit,
        input sqN,
        input loadSqN,
        input pc
    );

endinterface

// ==== hdl/loadEntryTable.sv ====
`timescale 1ns/10ps

module loadEntryTable
    import lbPkg::*;
#(
    parameter int NUM_ENTRIES = 8
) (
    input  logic    clk,
    input  logic    rst,

    input  logic    load0Valid,
    input  loadSqnT load0LoadSqN,
    input  addrT    load0Addr,
    input  accSizeT load0Size,

    input  logic    load1Valid,
    input  loadSqnT load1LoadSqN,
    input  addrT    load1Addr,
    input  accSizeT load1Size,

    input  loadSqnT comLoadSqN,
    input  logic    flushValid,
    input  loadSqnT flushLoadSqN,

    output loadSqnT maxLoadSqN,

    lbEntryIf.tableSide entries
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);
    localparam int TAG_W = SQN_WIDTH - IDX_W;

    // The table is indexed by the low bits of the sequence number
    if (NUM_ENTRIES < 2 || NUM_ENTRIES > 64 || (1 << IDX_W) != NUM_ENTRIES) begin : gSizeCheck
        $error("NUM_ENTRIES must be a power of two between 2 and 64");
    end

    logic [NUM_ENTRIES-1:0] validQ;
    logic [NUM_ENTRIES-1:0] validNext;
    logic [TAG_W-1:0]       tagQ     [NUM_ENTRIES];
    addrT                   addrQ    [NUM_ENTRIES];
    accSizeT                sizeQ    [NUM_ENTRIES];
    loadSqnT                entrySqN [NUM_ENTRIES];

    logic [IDX_W-1:0] load0Idx;
    logic [IDX_W-1:0] load1Idx;
    logic             load0Keep;
    logic             load1Keep;
    loadSqnT          load0Offset;
    loadSqnT          load1Offset;

    assign load0Idx = load0LoadSqN[IDX_W-1:0];
    assign load1Idx = load1LoadSqN[IDX_W-1:0];

    // A load that arrives together with a flush survives only if it is older
    assign load0Keep = load0Valid && !(flushValid && isNotOlder(flushLoadSqN, load0LoadSqN));
    assign load1Keep = load1Valid && !(flushValid && isNotOlder(flushLoadSqN, load1LoadSqN));

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            entrySqN[i] = {tagQ[i], IDX_W'(i)};
        end
    end

    // Commit freeing first, then the flush, then the new loads
    always_comb begin
        validNext = validQ;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!isNotOlder(comLoadSqN, entrySqN[i])) begin
                validNext[i] = 1'b0;
            end
            if (flushValid && isNotOlder(flushLoadSqN, entrySqN[i])) begin
                validNext[i] = 1'b0;
            end
        end
        if (load0Keep) begin
            validNext[load0Idx] = 1'b1;
        end
        if (load1Keep) begin
            validNext[load1Idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= '0;
        end else begin
            validQ <= validNext;
        end
    end

    // Payload is written even for a dropped load whose valid bit stays clear
    always_ff @(posedge clk) begin
        if (load0Valid) begin
            tagQ[load0Idx]  <= load0LoadSqN[SQN_WIDTH-1:IDX_W];
            addrQ[load0Idx] <= load0Addr;
            sizeQ[load0Idx] <= load0Size;
        end
        if (load1Valid) begin
            tagQ[load1Idx]  <= load1LoadSqN[SQN_WIDTH-1:IDX_W];
            addrQ[load1Idx] <= load1Addr;
            sizeQ[load1Idx] <= load1Size;
        end
    end

    // Youngest load number that still fits lags the commit pointer by one cycle
    always_ff @(posedge clk) begin
        maxLoadSqN <= comLoadSqN + loadSqnT'(NUM_ENTRIES - 1);
    end

    assign entries.valid   = validQ;
    assign entries.loadSqN = entrySqN;
    assign entries.addr    = addrQ;
    assign entries.size    = sizeQ;

    assign load0Offset = load0LoadSqN - comLoadSqN;
    assign load1Offset = load1LoadSqN - comLoadSqN;

    // Rename must never hand out a load number outside the free window
    property pInWindow(logic valid, loadSqnT offset);
        @(posedge clk) disable iff (rst)
            valid |-> (offset < NUM_ENTRIES);
    endproperty

    aLoad0InWindow: assert property (pInWindow(load0Valid, load0Offset))
        else $error("Port 0 load %h outside window at %h", load0LoadSqN, comLoadSqN);
    aLoad1InWindow: assert property (pInWindow(load1Valid, load1Offset))
        else $error("Port 1 load %h outside window at %h", load1LoadSqN, comLoadSqN);

endmodule

// ==== hdl/storeConflictCheck.sv ====
`timescale 1ns/10ps

module storeConflictCheck
    import lbPkg::*;
#(
    parameter int NUM_ENTRIES = 8
) (
    input  logic    storeValid,
    input  sqnT     storeSqN,
    input  loadSqnT storeLoadSqN,
    input  addrT    storeAddr,
    input  accSizeT storeSize,
    input  pcT      storePc,

    lbEntryIf.checkerSide entries,
    conflictIf.reporter   report
);

    logic [NUM_ENTRIES-1:0] younger;
    logic [NUM_ENTRIES-1:0] overlap;
    logic [NUM_ENTRIES-1:0] match;

    // Only loads at or after the store's load number can have read stale data
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            younger[i] = isNotOlder(storeLoadSqN, entries.loadSqN[i]);
            overlap[i] = bytesOverlap(storeAddr, storeSize, entries.addr[i], entries.size[i]);
            match[i]   = entries.valid[i] && younger[i] && overlap[i];
        end
    end

    // Order among the matching loads does not matter because the rollback goes to the store
    assign report.hit     = storeValid && (|match);
    assign report.sqN     = storeSqN;
    assign report.loadSqN = storeLoadSqN;
    assign report.pc      = storePc;

endmodule

// ==== hdl/rollbackArbiter.sv ====
`timescale 1ns/10ps

module rollbackArbiter
    import lbPkg::*;
(
    input  logic    clk,
    input  logic    rst,

    conflictIf.arbiter port0,
    conflictIf.arbiter port1,

    output logic    rollbackValid,
    output sqnT     rollbackSqN,
    output loadSqnT rollbackLoadSqN,
    output pcT      rollbackPc
);

    logic    anyHit;
    logic    pickPort1;
    sqnT     selSqN;
    loadSqnT selLoadSqN;
    pcT      selPc;

    assign anyHit = port0.hit || port1.hit;

    // Port 1 wins only when it alone hits or its store is strictly older
    assign pickPort1 = port1.hit && (!port0.hit || !isNotOlder(port0.sqN, port1.sqN));

    always_comb begin
        if (pickPort1) begin
            selSqN     = port1.sqN;
            selLoadSqN = port1.loadSqN;
            selPc      = port1.pc;
        end else begin
            selSqN     = port0.sqN;
            selLoadSqN = port0.loadSqN;
            selPc      = port0.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rollbackValid <= 1'b0;
        end else begin
            rollbackValid <= anyHit;
        end
    end

    // Fetch restarts at the instruction after the store
    always_ff @(posedge clk) begin
        rollbackSqN     <= selSqN;
        rollbackLoadSqN <= selLoadSqN;
        rollbackPc      <= selPc + pcT'(4);
    end

    // Two stores in one cycle are distinct instructions and cannot share an age
    aDistinctStores: assert property (
        @(posedge clk) disable iff (rst)
            (port0.hit && port1.hit) |-> (port0.sqN != port1.sqN)
    ) else $error("Both ports hit with store sequence number %h", port0.sqN);

endmodule

// ==== hdl/loadBuffer.sv ====
`timescale 1ns/10ps

module loadBuffer
    import lbPkg::*;
#(
    parameter int NUM_ENTRIES = 8
) (
    input  logic    clk,
    input  logic    rst,

    input  logic    store0Valid,
    input  sqnT     store0SqN,
    input  loadSqnT store0LoadSqN,
    input  addrT    store0Addr,
    input  accSizeT store0Size,
    input  pcT      store0Pc,

    input  logic    store1Valid,
    input  sqnT     store1SqN,
    input  loadSqnT store1LoadSqN,
    input  addrT    store1Addr,
    input  accSizeT store1Size,
    input  pcT      store1Pc,

    input  logic    load0Valid,
    input  loadSqnT load0LoadSqN,
    input  addrT    load0Addr,
    input  accSizeT load0Size,

    input  logic    load1Valid,
    input  loadSqnT load1LoadSqN,
    input  addrT    load1Addr,
    input  accSizeT load1Size,

    input  loadSqnT comLoadSqN,
    input  logic    flushValid,
    input  loadSqnT flushLoadSqN,

    output logic    rollbackValid,
    output sqnT     rollbackSqN,
    output loadSqnT rollbackLoadSqN,
    output pcT      rollbackPc,
    output loadSqnT maxLoadSqN
);

    lbEntryIf #(.NUM_ENTRIES(NUM_ENTRIES)) entryBus ();
    conflictIf port0Report ();
    conflictIf port1Report ();

    loadEntryTable #(.NUM_ENTRIES(NUM_ENTRIES)) entryTable (
        .clk, .rst,
        .load0Valid, .load0LoadSqN, .load0Addr, .load0Size,
        .load1Valid, .load1LoadSqN, .load1Addr, .load1Size,
        .comLoadSqN, .flushValid, .flushLoadSqN,
        .maxLoadSqN,
        .entries(entryBus.tableSide)
    );

    storeConflictCheck #(.NUM_ENTRIES(NUM_ENTRIES)) port0Check (
        .storeValid(store0Valid), .storeSqN(store0SqN), .storeLoadSqN(store0LoadSqN),
        .storeAddr(store0Addr), .storeSize(store0Size), .storePc(store0Pc),
        .entries(entryBus.checkerSide),
        .report(port0Report.reporter)
    );

    storeConflictCheck #(.NUM_ENTRIES(NUM_ENTRIES)) port1Check (
        .storeValid(store1Valid), .storeSqN(store1SqN), .storeLoadSqN(store1LoadSqN),
        .storeAddr(store1Addr), .storeSize(store1Size), .storePc(store1Pc),
        .entries(entryBus.checkerSide),
        .report(port1Report.reporter)
    );

    rollbackArbiter arbiter (
        .clk, .rst,
        .port0(port0Report.arbiter),
        .port1(port1Report.arbiter),
        .rollbackValid, .rollbackSqN, .rollbackLoadSqN, .rollbackPc
    );

endmodule

// ==== sim/clockGen.sv ====
`timescale 1ns/10ps

// Free-running 100 ns clock with a reset held over the first two rising edges
module clockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (2) begin
            @(posedge clk);
        end
        rst <= 1'b0;
    end

endmodule

// ==== sim/loadBufferTb.sv ====
`timescale 1ns/10ps

module loadBufferTb
    import lbPkg::*;
();

    localparam int NUM_ENTRIES = 8;
    localparam int RANDOM_CYCLES = 3000;

    logic    clk;
    logic    rst;
    logic    store0Valid, store1Valid, load0Valid, load1Valid, flushValid;
    sqnT     store0SqN, store1SqN;
    loadSqnT store0LoadSqN, store1LoadSqN, load0LoadSqN, load1LoadSqN;
    loadSqnT comLoadSqN, flushLoadSqN, maxLoadSqN, rollbackLoadSqN;
    addrT    store0Addr, store1Addr, load0Addr, load1Addr;
    accSizeT store0Size, store1Size, load0Size, load1Size;
    pcT      store0Pc, store1Pc, rollbackPc;
    logic    rollbackValid;
    sqnT     rollbackSqN;

    // Reference copy of the load table
    logic    mValid [NUM_ENTRIES];
    loadSqnT mSqN   [NUM_ENTRIES];
    addrT    mAddr  [NUM_ENTRIES];
    accSizeT mSize  [NUM_ENTRIES];

    logic    expRbValid;
    sqnT     expRbSqN;
    loadSqnT expRbLoadSqN;
    pcT      expRbPc;
    loadSqnT expMax;
    int      rbCount;

    clockGen clocks (.clk(clk), .rst(rst));

    loadBuffer #(.NUM_ENTRIES(NUM_ENTRIES)) UUT (.*);

    // Strictly earlier in wraparound order
    function automatic logic precedes(input logic [SQN_WIDTH-1:0] a,
                                      input logic [SQN_WIDTH-1:0] b);
        logic signed [SQN_WIDTH-1:0] d;
        d = a - b;
        return d < 0;
    endfunction

    function automatic logic overlapsRule(input addrT sa, input accSizeT ss,
                                          input addrT la, input accSizeT ls);
        if (sa[31:2] != la[31:2]) return 1'b0;
        if (ss >= 2) return 1'b1;
        if (ss == 1) return (ls >= 2) || (la[1] == sa[1]);
        return (ls >= 1) || (la[1:0] == sa[1:0]);
    endfunction

    function automatic logic storeHits(input logic v, input loadSqnT ld,
                                       input addrT a, input accSizeT s);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (v && mValid[i] && !precedes(mSqN[i], ld)
                    && overlapsRule(a, s, mAddr[i], mSize[i]))
                hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic failRun(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkRollback(input logic expV, input sqnT expS, input loadSqnT expL,
                                 input pcT expP, input logic actV, input sqnT actS,
                                 input loadSqnT actL, input pcT actP);
        if (actV !== expV)
            failRun($sformatf("mismatch rollbackValid: expected %h got %h", expV, actV));
        if (expV && actS !== expS)
            failRun($sformatf("mismatch rollbackSqN: expected %h got %h", expS, actS));
        if (expV && actL !== expL)
            failRun($sformatf("mismatch rollbackLoadSqN: expected %h got %h", expL, actL));
        if (expV && actP !== expP)
            failRun($sformatf("mismatch rollbackPc: expected %h got %h", expP, actP));
    endtask

    task automatic checkLimit(input loadSqnT expL, input loadSqnT actL);
        if (actL !== expL)
            failRun($sformatf("mismatch maxLoadSqN: expected %h got %h", expL, actL));
    endtask

    // Applies what the DUT sampled at this edge to the model
    task automatic updateModel();
        logic hit0;
        logic hit1;
        logic pick1;
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) mValid[i] = 1'b0;
            expRbValid = 1'b0;
        end else begin
            hit0  = storeHits(store0Valid, store0LoadSqN, store0Addr, store0Size);
            hit1  = storeHits(store1Valid, store1LoadSqN, store1Addr, store1Size);
            pick1 = hit1 && (!hit0 || precedes(store1SqN, store0SqN));
            expRbValid   = hit0 || hit1;
            expRbSqN     = pick1 ? store1SqN : store0SqN;
            expRbLoadSqN = pick1 ? store1LoadSqN : store0LoadSqN;
            expRbPc      = (pick1 ? store1Pc : store0Pc) + 32'd4;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (precedes(mSqN[i], comLoadSqN)) mValid[i] = 1'b0;
                if (flushValid && !precedes(mSqN[i], flushLoadSqN)) mValid[i] = 1'b0;
            end
            if (load0Valid) begin
                mSqN[load0LoadSqN % NUM_ENTRIES]  = load0LoadSqN;
                mAddr[load0LoadSqN % NUM_ENTRIES] = load0Addr;
                mSize[load0LoadSqN % NUM_ENTRIES] = load0Size;
                if (!(flushValid && !precedes(load0LoadSqN, flushLoadSqN)))
                    mValid[load0LoadSqN % NUM_ENTRIES] = 1'b1;
            end
            if (load1Valid) begin
                mSqN[load1LoadSqN % NUM_ENTRIES]  = load1LoadSqN;
                mAddr[load1LoadSqN % NUM_ENTRIES] = load1Addr;
                mSize[load1LoadSqN % NUM_ENTRIES] = load1Size;
                if (!(flushValid && !precedes(load1LoadSqN, flushLoadSqN)))
                    mValid[load1LoadSqN % NUM_ENTRIES] = 1'b1;
            end
        end
        expMax = loadSqnT'(comLoadSqN + NUM_ENTRIES - 1);
    endtask

    // Check outputs at the falling edge, then advance one rising edge and drop the strobes
    task automatic step();
        @(negedge clk);
        if (rollbackValid === 1'b1) rbCount++;
        checkRollback(expRbValid, expRbSqN, expRbLoadSqN, expRbPc,
                      rollbackValid, rollbackSqN, rollbackLoadSqN, rollbackPc);
        checkLimit(expMax, maxLoadSqN);
        @(posedge clk);
        updateModel();
        store0Valid <= 1'b0;
        store1Valid <= 1'b0;
        load0Valid  <= 1'b0;
        load1Valid  <= 1'b0;
        flushValid  <= 1'b0;
    endtask

    task automatic expectRollbacks(input int target);
        int waited;
        waited = 0;
        while (rbCount < target && waited < 5) begin
            step();
            waited++;
        end
        if (rbCount != target)
            failRun($sformatf("expected %0d rollbacks so far but saw %0d", target, rbCount));
    endtask

    task automatic driveStore0(input sqnT s, input loadSqnT l, input addrT a,
                               input accSizeT z, input pcT p);
        store0Valid <= 1'b1;
        store0SqN <= s;
        store0LoadSqN <= l;
        store0Addr <= a;
        store0Size <= z;
        store0Pc <= p;
    endtask

    task automatic driveLoad0(input loadSqnT l, input addrT a, input accSizeT z);
        load0Valid <= 1'b1;
        load0LoadSqN <= l;
        load0Addr <= a;
        load0Size <= z;
    endtask

    task automatic driveRandom();
        loadSqnT com;
        sqnT     s0;
        sqnT     ageGap;
        com = comLoadSqN + loadSqnT'($urandom % 4 == 0);
        comLoadSqN <= com;
        load0Valid <= $urandom % 2;
        load0LoadSqN <= com + loadSqnT'($urandom % 4);
        load0Addr <= 32'h1000 + ($urandom % 16);
        load0Size <= $urandom % 3;
        load1Valid <= $urandom % 2;
        load1LoadSqN <= com + loadSqnT'(4 + $urandom % 4);
        load1Addr <= 32'h1000 + ($urandom % 16);
        load1Size <= $urandom % 3;
        // Two stores in flight stay within half the sequence space of each other
        s0 = $urandom;
        ageGap = sqnT'(1 + $urandom % 63);
        store0Valid <= $urandom % 2;
        store0SqN <= s0;
        store0LoadSqN <= com + loadSqnT'($urandom % 8);
        store0Addr <= 32'h1000 + ($urandom % 16);
        store0Size <= $urandom % 3;
        store0Pc <= $urandom;
        store1Valid <= $urandom % 2;
        store1SqN <= ($urandom % 2) ? s0 + ageGap : s0 - ageGap;
        store1LoadSqN <= com + loadSqnT'($urandom % 8);
        store1Addr <= 32'h1000 + ($urandom % 16);
        store1Size <= $urandom % 3;
        store1Pc <= $urandom;
        flushValid <= ($urandom % 16 == 0);
        flushLoadSqN <= com + loadSqnT'($urandom % 8);
    endtask

    initial begin
        int waited;
        void'($urandom(11990));
        {store0Valid, store1Valid, load0Valid, load1Valid, flushValid} = '0;
        {store0SqN, store1SqN, store0LoadSqN, store1LoadSqN} = '0;
        {load0LoadSqN, load1LoadSqN, comLoadSqN, flushLoadSqN} = '0;
        {store0Addr, store1Addr, load0Addr, load1Addr} = '0;
        {store0Size, store1Size, load0Size, load1Size} = '0;
        {store0Pc, store1Pc} = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) mValid[i] = 1'b0;
        expRbValid = 1'b0;
        rbCount = 0;
        waited = 0;
        @(posedge clk);
        updateModel();
        while (rst !== 1'b0 && waited < 10) begin
            step();
            waited++;
        end
        if (rst !== 1'b0) failRun("reset never released");
        step();

        // Younger load overlapped by an older store
        driveLoad0(7'd3, 32'h100, 2'd2);
        step();
        driveStore0(7'd20, 7'd2, 32'h102, 2'd0, 32'h400);
        step();
        expectRollbacks(1);

        // Older load, disjoint bytes and a load in the same cycle give nothing
        driveStore0(7'd21, 7'd4, 32'h100, 2'd2, 32'h410);
        step();
        load1Valid <= 1'b1;
        load1LoadSqN <= 7'd5;
        load1Addr <= 32'h301;
        load1Size <= 2'd0;
        step();
        driveStore0(7'd22, 7'd0, 32'h300, 2'd0, 32'h420);
        step();
        driveLoad0(7'd6, 32'h500, 2'd2);
        driveStore0(7'd23, 7'd0, 32'h500, 2'd2, 32'h430);
        step();
        step();
        step();

        // Commit frees load 3 and the flush removes loads 5 and 6
        comLoadSqN <= 7'd4;
        step();
        driveStore0(7'd24, 7'd0, 32'h100, 2'd2, 32'h440);
        flushValid <= 1'b1;
        flushLoadSqN <= 7'd5;
        step();
        driveStore0(7'd25, 7'd4, 32'h500, 2'd2, 32'h450);
        step();
        step();
        expectRollbacks(1);

        // Both ports hit and port 1 holds the older store
        driveLoad0(7'd7, 32'h600, 2'd2);
        step();
        driveStore0(7'd30, 7'd5, 32'h600, 2'd2, 32'h600);
        store1Valid <= 1'b1;
        store1SqN <= 7'd25;
        store1LoadSqN <= 7'd6;
        store1Addr <= 32'h602;
        store1Size <= 2'd1;
        store1Pc <= 32'h700;
        step();
        expectRollbacks(2);

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            driveRandom();
            step();
        end
        step();
        step();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
hdl/lbPkg.sv
hdl/lbEntryIf.sv
hdl/conflictIf.sv
hdl/loadEntryTable.sv
hdl/storeConflictCheck.sv
hdl/rollbackArbiter.sv
hdl/loadBuffer.sv
sim/clockGen.sv
sim/loadBufferTb.sv

// ==== Bender.yml ====
package:
  name: load_buffer

sources:
  - hdl/lbPkg.sv
  - hdl/lbEntryIf.sv
  - hdl/conflictIf.sv
  - hdl/loadEntryTable.sv
  - hdl/storeConflictCheck.sv
  - hdl/rollbackArbiter.sv
  - hdl/loadBuffer.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/loadBufferTb.sv
